//--- rtl/prbs_pkg.sv
package prbs_pkg;

    // one received word is one lane per bit
    localparam int prbs_n_channels = 16;

    // PRBS7 generator polynomial x^7 + x^6 + 1
    localparam int prbs_order = 7;

    // feedback taps on state bits 6 and 5
    localparam logic [prbs_order-1:0] prbs_taps = 7'b110_0000;

    // bit offset within one word, 0 to 15
    localparam int prbs_shift_bits = $clog2(prbs_n_channels);

    // checker mode codes, 2'b11 is decoded as test as well
    localparam logic [1:0] mode_reset = 2'b00;
    localparam logic [1:0] mode_align = 2'b01;
    localparam logic [1:0] mode_test  = 2'b10;

    // width of the correct and total bit counters
    localparam int count_bits = 64;

endpackage

//--- rtl/prbs_lfsr.sv
module prbs_lfsr import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       cke,
    input  logic [prbs_order-1:0]      init,
    output logic [prbs_n_channels-1:0] word
);

    // current LFSR state, first bit of the next word is state[6]
    logic [prbs_order-1:0] state;

    // state and word after sixteen serial steps
    logic [prbs_order-1:0]      step_state;
    logic [prbs_n_channels-1:0] step_word;

    // unroll one word worth of serial steps
    // bit k of the word is the k-th bit out of the register
    always_comb begin
        step_state = state;
        for (int k = 0; k < prbs_n_channels; k++) begin
            step_word[k] = step_state[prbs_order-1];
            step_state   = {step_state[prbs_order-2:0], ^(step_state & prbs_taps)};
        end
    end

    // state register, load wins over cke
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '1;
        end else if (load) begin
            state <= init;
        end else if (cke) begin
            state <= step_state;
        end
    end

    // output word register, held while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word <= '0;
        end else if (!load && cke) begin
            word <= step_word;
        end
    end

    // an all-zero seed would lock the sequence up for good
    a_state_not_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |=> (state != '0)
    );

endmodule

//--- rtl/prbs_generator.sv
module prbs_generator import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       gen_run,
    input  logic [prbs_order-1:0]      prbs_init,
    output logic [prbs_n_channels-1:0] tx_bits
);

    // LFSR control derived from the run level
    logic lfsr_load;
    logic lfsr_cke;

    // seed is reloaded for as long as the source is stopped
    assign lfsr_load = !gen_run;

    // one word per clock while running
    assign lfsr_cke = gen_run;

    // the LFSR word register is the transmit word
    prbs_lfsr lfsr0 (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (lfsr_load),
        .cke   (lfsr_cke),
        .init  (prbs_init),
        .word  (tx_bits)
    );

    // a running source never repeats a word on consecutive clocks
    a_tx_advances: assert property (
        @(posedge clk) disable iff (!rst_n)
        gen_run ##1 gen_run |=> (tx_bits != $past(tx_bits))
    );

endmodule

//--- rtl/prbs_checker_core.sv
module prbs_checker_core import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       core_load,
    input  logic                       core_cke,
    input  logic [prbs_order-1:0]      prbs_init,
    input  logic [prbs_n_channels-1:0] rx_bits,
    input  logic [prbs_shift_bits-1:0] rx_shift,
    output logic                       match
);

    // last two received words, rx_old came first on the line
    logic [prbs_n_channels-1:0] rx_new;
    logic [prbs_n_channels-1:0] rx_old;

    // two words laid end to end in serial order
    logic [2*prbs_n_channels-1:0] rx_window;

    // sixteen serial bits starting at rx_shift inside rx_old
    logic [prbs_n_channels-1:0] rx_sel;

    // local copy of the expected sequence
    logic [prbs_n_channels-1:0] ref_word;

    // receive history, plain data registers
    always_ff @(posedge clk) begin
        rx_new <= rx_bits;
        rx_old <= rx_new;
    end

    // older word in the low half so serial bit order runs upwards
    assign rx_window = {rx_new, rx_old};

    // barrel shift down by the bit offset
    always_comb begin
        rx_sel = '0;
        for (int k = 0; k < prbs_n_channels; k++) begin
            rx_sel[k] = rx_window[k + int'(rx_shift)];
        end
    end

    // local PRBS, a low core_cke slips it one word against the stream
    prbs_lfsr lfsr0 (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (core_load),
        .cke   (core_cke),
        .init  (prbs_init),
        .word  (ref_word)
    );

    // full-word compare
    assign match = (rx_sel == ref_word);

endmodule

//--- rtl/prbs_checker.sv
module prbs_checker import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 checker_mode,
    input  logic [prbs_order-1:0]      prbs_init,
    input  logic [prbs_n_channels-1:0] rx_bits,
    output logic [count_bits-1:0]      correct_bits,
    output logic [count_bits-1:0]      total_bits
);

    // controls into the core
    logic                       core_load;
    logic                       core_cke;
    logic [prbs_shift_bits-1:0] rx_shift;

    // word compare result from the core
    logic core_match;

    prbs_checker_core core0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .core_load (core_load),
        .core_cke  (core_cke),
        .prbs_init (prbs_init),
        .rx_bits   (rx_bits),
        .rx_shift  (rx_shift),
        .match     (core_match)
    );

    // mode controller and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_load    <= 1'b1;
            core_cke     <= 1'b0;
            rx_shift     <= '1;
            correct_bits <= '0;
            total_bits   <= '0;
        end else begin
            case (checker_mode)
                mode_reset: begin
                    core_load    <= 1'b1;
                    core_cke     <= 1'b0;
                    rx_shift     <= '1;
                    correct_bits <= '0;
                    total_bits   <= '0;
                end
                mode_align: begin
                    core_load <= 1'b0;
                    if (core_match) begin
                        // locked, keep the offset and run
                        core_cke <= 1'b1;
                    end else if (rx_shift == '0) begin
                        // all offsets tried, slip one word and start over
                        core_cke <= 1'b0;
                        rx_shift <= '1;
                    end else begin
                        core_cke <= 1'b1;
                        rx_shift <= rx_shift - 1'b1;
                    end
                    correct_bits <= '0;
                    total_bits   <= '0;
                end
                mode_test, 2'b11: begin
                    core_load  <= 1'b0;
                    core_cke   <= 1'b1;
                    total_bits <= total_bits + 1'b1;
                    if (core_match) begin
                        correct_bits <= correct_bits + 1'b1;
                    end
                end
            endcase
        end
    end

    // counters only move in test mode
    a_idle_counters_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (checker_mode == mode_reset || checker_mode == mode_align)
            |=> (total_bits == '0 && correct_bits == '0)
    );

    // every correct word was also counted as compared
    a_correct_le_total: assert property (
        @(posedge clk) disable iff (!rst_n)
        correct_bits <= total_bits
    );

endmodule

//--- rtl/prbs_test_top.sv
module prbs_test_top import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    // shared PRBS seed for both sides
    input  logic [prbs_order-1:0]      prbs_init,

    // transmit side
    input  logic                       gen_run,
    output logic [prbs_n_channels-1:0] tx_bits,

    // receive side, recovered words from the deserializer
    input  logic [prbs_n_channels-1:0] rx_bits,
    input  logic [1:0]                 checker_mode,
    output logic [count_bits-1:0]      correct_bits,
    output logic [count_bits-1:0]      total_bits
);

    // transmit word source
    prbs_generator gen0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .gen_run   (gen_run),
        .prbs_init (prbs_init),
        .tx_bits   (tx_bits)
    );

    // receive checker with alignment search and counters
    prbs_checker chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .checker_mode (checker_mode),
        .prbs_init    (prbs_init),
        .rx_bits      (rx_bits),
        .correct_bits (correct_bits),
        .total_bits   (total_bits)
    );

endmodule

//--- sim/tb_prbs_test.sv
module tb_prbs_test import prbs_pkg::*; ();

    // PRBS seed, channel and error settings of this bench
    localparam logic [prbs_order-1:0] prbs_seed   = 7'h2d;
    localparam logic [31:0]           rand_seed   = 32'd67686;
    localparam int                    prbs_period = 127;
    localparam int                    hist_bits   = 5 * prbs_n_channels;
    localparam int                    max_delay   = 47;
    localparam int                    flip_count  = 12;
    localparam int                    gen_words   = 300;
    localparam int                    align_len   = 2500;
    localparam int                    test_len    = 500;
    localparam int                    run_limit   = 10000;

    // DUT ports
    logic                       clk;
    logic                       rst_n;
    logic [prbs_order-1:0]      prbs_init;
    logic                       gen_run;
    logic [prbs_n_channels-1:0] rx_bits;
    logic [1:0]                 checker_mode;
    logic [prbs_n_channels-1:0] tx_bits;
    logic [count_bits-1:0]      correct_bits;
    logic [count_bits-1:0]      total_bits;

    // channel model state, newest word in the top bits
    logic [hist_bits-1:0]       line_hist;
    logic [prbs_n_channels-1:0] flip_mask;
    int                         line_delay;

    // bookkeeping
    logic [31:0] rand_state;
    int          error_count;
    int          check_count;
    int          gen_checked;
    int          gen_index;
    logic        gen_was_running;

    prbs_test_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .prbs_init    (prbs_init),
        .gen_run      (gen_run),
        .tx_bits      (tx_bits),
        .rx_bits      (rx_bits),
        .checker_mode (checker_mode),
        .correct_bits (correct_bits),
        .total_bits   (total_bits)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word t of the serial sequence started from seed
    // out bit is s[6], then s[6]^s[5] enters at bit 0
    function automatic logic [prbs_n_channels-1:0] prbs_ref_word(
        input logic [prbs_order-1:0] seed,
        input int                    t
    );
        logic [prbs_order-1:0]      s;
        logic [prbs_n_channels-1:0] w;
        int                         skip;
        s = seed;
        w = '0;
        // the sequence repeats every 127 bits
        skip = (t * prbs_n_channels) % prbs_period;
        for (int i = 0; i < skip + prbs_n_channels; i++) begin
            if (i >= skip) begin
                w[i - skip] = s[6];
            end
            s = {s[5:0], s[6] ^ s[5]};
        end
        return w;
    endfunction

    task automatic check_value(
        input string                 what,
        input logic [count_bits-1:0] got,
        input logic [count_bits-1:0] exp
    );
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // one clock of the channel: take the tx word, drive the delayed rx word
    task automatic next_cycle();
        @(negedge clk);
        line_hist = {tx_bits, line_hist[hist_bits-1:prbs_n_channels]};
        for (int k = 0; k < prbs_n_channels; k++) begin
            rx_bits[k] = line_hist[hist_bits - prbs_n_channels + k - line_delay]
                         ^ flip_mask[k];
        end
        flip_mask = '0;
    endtask

    task automatic run_cycles(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
        end
    endtask

    // align mode, counters must stay at zero all along
    task automatic run_align(input int cycles);
        checker_mode = mode_align;
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            check_value("total_bits in align", total_bits, '0);
            check_value("correct_bits in align", correct_bits, '0);
        end
    endtask

    // test mode, one compared word per clock and no errors on a clean line
    task automatic run_test(input logic [1:0] mode, input int cycles, input bit clean);
        checker_mode = mode;
        for (int c = 1; c <= cycles; c++) begin
            next_cycle();
            check_value("total_bits in test", total_bits, count_bits'(c));
        end
        if (clean) begin
            check_value("correct_bits after test", correct_bits, count_bits'(cycles));
        end
    endtask

    task automatic clear_counters();
        checker_mode = mode_reset;
        next_cycle();
        check_value("total_bits after reset mode", total_bits, '0);
        check_value("correct_bits after reset mode", correct_bits, '0);
    endtask

    task automatic pick_delay();
        int old_delay;
        int tries;
        old_delay = line_delay;
        tries = 0;
        do begin
            rand_state = xorshift32(rand_state);
            line_delay = int'(rand_state % (max_delay + 1));
            tries++;
        end while (line_delay == old_delay && tries < 20);
        $display("channel delay set to %0d bits", line_delay);
    endtask

    // single bit flips on the rx line, at least two words apart
    task automatic inject_flips(input int count);
        int gap;
        int pos;
        for (int f = 0; f < count; f++) begin
            rand_state = xorshift32(rand_state);
            gap = 2 + int'(rand_state % 3);
            rand_state = xorshift32(rand_state);
            pos = int'(rand_state % prbs_n_channels);
            run_cycles(gap - 1);
            flip_mask = '0;
            flip_mask[pos] = 1'b1;
            next_cycle();
        end
    endtask

    // generator compare, tx_bits sampled before each edge updates it
    always @(posedge clk) begin
        if (!rst_n) begin
            gen_was_running <= 1'b0;
            gen_index       <= 0;
        end else begin
            if (gen_was_running) begin
                check_value("tx_bits word", tx_bits, prbs_ref_word(prbs_seed, gen_index));
                gen_checked <= gen_checked + 1;
            end
            gen_was_running <= gen_run;
            if (gen_run) begin
                gen_index <= gen_was_running ? gen_index + 1 : 0;
            end else begin
                gen_index <= 0;
            end
        end
    end

    // overall limit on the run
    initial begin
        repeat (run_limit) @(posedge clk);
        $display("simulation stopped: run did not complete within %0d cycles", run_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int waited;
        rst_n        = 1'b0;
        prbs_init    = prbs_seed;
        gen_run      = 1'b0;
        rx_bits      = '0;
        checker_mode = mode_reset;
        line_hist    = '0;
        flip_mask    = '0;
        line_delay   = 0;
        rand_state   = rand_seed;
        error_count  = 0;
        check_count  = 0;
        gen_checked  = 0;
        gen_index    = 0;

        run_cycles(3);
        rst_n = 1'b1;
        run_cycles(2);

        // generator sequence from the seed
        gen_run = 1'b1;
        waited = 0;
        while (gen_checked < gen_words && waited < gen_words + 100) begin
            next_cycle();
            waited++;
        end
        if (gen_checked < gen_words) begin
            error_count++;
            $display("timeout: generator check saw only %0d of %0d words",
                     gen_checked, gen_words);
        end

        // counters after reset, a short unaligned count, then clear again
        check_value("total_bits after rst_n", total_bits, '0);
        check_value("correct_bits after rst_n", correct_bits, '0);
        run_test(mode_test, 20, 1'b0);
        clear_counters();

        // first alignment on a random channel delay
        pick_delay();
        run_cycles(4);
        clear_counters();
        run_align(align_len);
        run_test(mode_test, test_len, 1'b1);

        // flipped bits show up one for one as missing correct words
        inject_flips(flip_count);
        run_cycles(4);
        check_value("missed words after flips", total_bits - correct_bits,
                    count_bits'(flip_count));

        // new delay, full reset, align and test sequence again
        pick_delay();
        run_cycles(4);
        clear_counters();
        run_cycles(1);
        run_align(align_len);
        // 2'b11 decodes as test too
        run_test(2'b11, test_len, 1'b1);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/prbs_pkg.sv
rtl/prbs_lfsr.sv
rtl/prbs_generator.sv
rtl/prbs_checker_core.sv
rtl/prbs_checker.sv
rtl/prbs_test_top.sv
sim/tb_prbs_test.sv

//--- Bender.yml
package:
  name: prbs_link_tester

sources:
  # design sources in compile order
  - files:
      - rtl/prbs_pkg.sv
      - rtl/prbs_lfsr.sv
      - rtl/prbs_generator.sv
      - rtl/prbs_checker_core.sv
      - rtl/prbs_checker.sv
      - rtl/prbs_test_top.sv

  # testbench, top module tb_prbs_test
  - target: simulation
    files:
      - sim/tb_prbs_test.sv
